// File: src.f
logic/bus_pkg.sv
logic/io_pkg.sv
logic/address_decoder.sv
logic/sram_bank.sv
logic/io_handler.sv
logic/data_bus_multiplexer.sv
logic/memory_bus_core.sv
verif/tb_clock_gen.sv
verif/memory_bus_tb.sv

// File: Bender.yml
package:
  name: memory_bus_core

sources:
  - logic/bus_pkg.sv
  - logic/io_pkg.sv
  - logic/address_decoder.sv
  - logic/sram_bank.sv
  - logic/io_handler.sv
  - logic/data_bus_multiplexer.sv
  - logic/memory_bus_core.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/memory_bus_tb.sv

// File: verif/memory_bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

module memory_bus_tb;
    import bus_pkg::*;
    import io_pkg::*;

    localparam logic [1:0] op_idle  = 2'd0;
    localparam logic [1:0] op_write = 2'd1;
    localparam logic [1:0] op_read  = 2'd2;

    localparam logic [addr_width-1:0] led_addr = io_base + ledr_offset;
    localparam logic [addr_width-1:0] sw_addr  = io_base + sw_offset;
    localparam logic [addr_width-1:0] hex_addr = io_base + hex_offset;

    // segment patterns for digits F down to 0, active low, bit 0 is segment a
    localparam logic [16*7-1:0] seg_patterns = {
        7'h0e, 7'h06, 7'h21, 7'h46, 7'h03, 7'h08, 7'h10, 7'h00,
        7'h78, 7'h02, 7'h12, 7'h19, 7'h30, 7'h24, 7'h79, 7'h40
    };
    localparam logic [15:0] partial_be = 16'b1010_1000_0110_0001;  // one be nibble per bank

    // one table row with the state expected one cycle after it
    typedef struct packed {
        logic [1:0]            op;
        logic [addr_width-1:0] addr;
        logic [be_width-1:0]   be;
        logic [data_width-1:0] wdata;
        logic [data_width-1:0] exp_rdata;
        logic [num_leds-1:0]   exp_ledr;
        logic [hex_width-1:0]  exp_hex;
    } row_t;

    logic                    clk;
    logic                    rst_n;
    logic                    as_n;
    bus_req_t                req;
    logic [num_switches-1:0] sw;
    logic [data_width-1:0]   rdata;
    logic [num_leds-1:0]     ledr;
    seg7_t                   hex_seg [num_digits];

    row_t                    rows [$];
    row_t                    prev;
    int                      prev_row;
    logic [data_width-1:0]   ram_model [num_banks*bank_words];
    logic [num_leds-1:0]     led_model;
    logic [hex_width-1:0]    hex_model;
    logic [num_switches-1:0] sw_value;
    integer                  seed;
    int                      errors;
    int                      checks;
    int                      cycles;
    int                      cycle_limit;

    tb_clock_gen u_clk (
        .clk (clk)
    );

    memory_bus_core UUT (
        .clk   (clk),
        .rst_n (rst_n),
        .as_n  (as_n),
        .req   (req),
        .sw    (sw),
        .rdata (rdata),
        .ledr  (ledr),
        .hex0  (hex_seg[0]),
        .hex1  (hex_seg[1]),
        .hex2  (hex_seg[2]),
        .hex3  (hex_seg[3]),
        .hex4  (hex_seg[4]),
        .hex5  (hex_seg[5])
    );

    function automatic logic [data_width-1:0] byte_mask(input logic [be_width-1:0] be);
        logic [data_width-1:0] mask;
        for (int lane = 0; lane < be_width; lane++) begin
            mask[lane*8 +: 8] = {8{be[lane]}};
        end
        return mask;
    endfunction

    function automatic logic [addr_width-1:0] ram_addr(input int bank, input int word);
        return ram_base + (bank * bank_words + word) * 4;
    endfunction

    function automatic logic ram_mapped(input logic [addr_width-1:0] addr);
        return (addr >= ram_base) && (addr < ram_base + num_banks * bank_words * 4);
    endfunction

    function automatic logic io_mapped(input logic [addr_width-1:0] addr);
        return addr[addr_width-1:12] == io_base[addr_width-1:12];
    endfunction

    task automatic add_write(input logic [addr_width-1:0] addr, input logic [be_width-1:0] be,
                             input logic [data_width-1:0] wdata);
        row_t                  r;
        logic [data_width-1:0] mask;
        mask = byte_mask(be);
        if (ram_mapped(addr)) begin
            ram_model[addr[11:2]] = (ram_model[addr[11:2]] & ~mask) | (wdata & mask);
        end else if (io_mapped(addr) && addr[11:0] == 12'h000) begin
            led_model = (led_model & ~mask[num_leds-1:0]) | (wdata[num_leds-1:0] & mask);
        end else if (io_mapped(addr) && addr[11:0] == 12'h008) begin
            hex_model = (hex_model & ~mask[hex_width-1:0]) | (wdata[hex_width-1:0] & mask);
        end
        r = '{op_write, addr, be, wdata, '0, led_model, hex_model};
        rows.push_back(r);
    endtask

    task automatic add_read(input logic [addr_width-1:0] addr);
        row_t                  r;
        logic [data_width-1:0] want;
        want = '0;
        if (ram_mapped(addr)) begin
            want = ram_model[addr[11:2]];
        end else if (io_mapped(addr)) begin
            case (addr[11:0])
                12'h000: want = {{(data_width-num_leds){1'b0}}, led_model};
                12'h004: want = {{(data_width-num_switches){1'b0}}, sw_value};
                12'h008: want = {{(data_width-hex_width){1'b0}}, hex_model};
                default: want = '0;  // hole in the register map
            endcase
        end
        r = '{op_read, addr, 4'hf, '0, want, led_model, hex_model};
        rows.push_back(r);
    endtask

    task automatic add_idle();
        row_t r;
        r = '{op_idle, '0, '0, '0, '0, led_model, hex_model};
        rows.push_back(r);
    endtask

    task automatic build_table();
        int word;
        for (int b = 0; b < num_banks; b++) begin
            for (int k = 0; k < 4; k++) begin
                word = (k == 0) ? 0 : (k == 1) ? 1 : (k == 2) ? 5 : 255;
                add_write(ram_addr(b, word), 4'hf, $random(seed));
            end
        end
        add_idle();
        for (int b = 0; b < num_banks; b++) begin
            add_write(ram_addr(b, 1), partial_be[b*4 +: 4], $random(seed));
        end
        add_write(ram_addr(3, 255), 4'b1100, $random(seed));
        add_read(ram_addr(3, 255));  // read right behind its write
        for (int b = 0; b < num_banks; b++) begin
            for (int k = 0; k < 4; k++) begin
                word = (k == 0) ? 0 : (k == 1) ? 1 : (k == 2) ? 5 : 255;
                add_read(ram_addr(b, word));
            end
        end
        add_idle();
        add_write(led_addr, 4'hf, $random(seed));
        add_read(led_addr);
        add_write(led_addr, 4'b0001, $random(seed));
        add_read(led_addr);
        add_write(led_addr, 4'b0010, $random(seed));
        add_read(sw_addr);
        add_write(hex_addr, 4'hf, 32'hff01_2345);
        add_write(hex_addr, 4'hf, 32'h5a67_89ab);
        add_write(hex_addr, 4'hf, 32'h00cd_ef01);
        add_write(hex_addr, 4'b0100, 32'h00ee_0000);
        add_read(hex_addr);
        add_idle();
        add_read(32'h0000_2000);
        add_read(32'h0002_0008);
        add_read(io_base + 32'h10);
        add_read(io_base + 32'h0c);
        add_write(32'h0000_2004, 4'hf, $random(seed));  // aliases bank 0 word 1
        add_write(32'h0001_1000, 4'hf, $random(seed));
        add_write(io_base + 32'h10, 4'hf, $random(seed));
        add_write(io_base + 32'h1008, 4'hf, $random(seed));
        add_read(ram_addr(0, 1));
        add_read(led_addr);
        add_read(hex_addr);
        add_read(ram_addr(0, 0));
        add_idle();
    endtask

    task automatic drive_row(input row_t r);
        as_n      = (r.op == op_idle);
        req.addr  = r.addr;
        req.wdata = r.wdata;
        req.be    = r.be;
        req.we    = (r.op == op_write);
    endtask

    task automatic check_outputs(input row_t want, input int row_num);
        seg7_t want_seg;
        checks++;
        if (rdata !== want.exp_rdata) begin
            $display("[FAIL] row %0d rdata: expected %h, got %h", row_num, want.exp_rdata, rdata);
            errors++;
        end
        checks++;
        if (ledr !== want.exp_ledr) begin
            $display("[FAIL] row %0d ledr: expected %h, got %h", row_num, want.exp_ledr, ledr);
            errors++;
        end
        for (int d = 0; d < num_digits; d++) begin
            want_seg = seg_patterns[want.exp_hex[d*4 +: 4]*7 +: 7];
            checks++;
            if (hex_seg[d] !== want_seg) begin
                $display("[FAIL] row %0d hex%0d: expected %h, got %h",
                         row_num, d, want_seg, hex_seg[d]);
                errors++;
            end
        end
    endtask

    // watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: the run went past %0d clock cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        seed        = 32'h2beb0067;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        cycle_limit = 32'h7fff_ffff;
        rst_n       = 1'b0;
        as_n        = 1'b1;
        req         = '0;
        sw          = '0;
        led_model   = '0;
        hex_model   = '0;
        sw_value    = $random(seed);
        sw          = sw_value;
        build_table();
        cycle_limit = rows.size() + 50;
        repeat (4) @(posedge clk);  // four rising edges in reset
        @(negedge clk);
        rst_n    = 1'b1;
        prev     = '{op_idle, '0, '0, '0, '0, '0, '0};  // state right after reset
        prev_row = -1;
        for (int i = 0; i < rows.size(); i++) begin
            @(negedge clk);
            check_outputs(prev, prev_row);
            drive_row(rows[i]);
            prev     = rows[i];
            prev_row = i;
        end
        @(negedge clk);
        check_outputs(prev, prev_row);
        as_n = 1'b1;
        $display("summary: %0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);
    localparam real half_period_ns = 2.0;  // 4 ns period

    initial begin
        clk = 1'b0;
    end

    always begin
        #(half_period_ns) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: logic/memory_bus_core.sv
`timescale 1ns/1ps
`default_nettype none

module memory_bus_core (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            as_n,
    input  bus_pkg::bus_req_t               req,
    input  logic [io_pkg::num_switches-1:0] sw,
    output logic [bus_pkg::data_width-1:0]  rdata,
    output logic [io_pkg::num_leds-1:0]     ledr,
    output io_pkg::seg7_t                   hex0,
    output io_pkg::seg7_t                   hex1,
    output io_pkg::seg7_t                   hex2,
    output io_pkg::seg7_t                   hex3,
    output io_pkg::seg7_t                   hex4,
    output io_pkg::seg7_t                   hex5
);
    import bus_pkg::*;

    logic [num_banks-1:0]  bank_sel;
    logic                  io_sel;
    logic [num_banks:0]    rd_sel;
    logic [data_width-1:0] bank_rdata [num_banks];
    logic [data_width-1:0] io_rdata;

    address_decoder u_decoder (
        .clk      (clk),
        .rst_n    (rst_n),
        .as_n     (as_n),
        .req      (req),
        .bank_sel (bank_sel),
        .io_sel   (io_sel),
        .rd_sel   (rd_sel)
    );

    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        sram_bank u_bank (
            .clk   (clk),
            .sel   (bank_sel[b]),
            .req   (req),
            .rdata (bank_rdata[b])
        );
    end

    io_handler u_io (
        .clk   (clk),
        .rst_n (rst_n),
        .sel   (io_sel),
        .req   (req),
        .sw    (sw),
        .rdata (io_rdata),
        .ledr  (ledr),
        .hex0  (hex0),
        .hex1  (hex1),
        .hex2  (hex2),
        .hex3  (hex3),
        .hex4  (hex4),
        .hex5  (hex5)
    );

    data_bus_multiplexer u_rd_mux (
        .rd_sel     (rd_sel),
        .bank_rdata (bank_rdata),
        .io_rdata   (io_rdata),
        .rdata      (rdata)
    );

endmodule

`default_nettype wire

// File: logic/data_bus_multiplexer.sv
`timescale 1ns/1ps
`default_nettype none

module data_bus_multiplexer (
    input  logic [bus_pkg::num_banks:0]    rd_sel,
    input  logic [bus_pkg::data_width-1:0] bank_rdata [bus_pkg::num_banks],
    input  logic [bus_pkg::data_width-1:0] io_rdata,
    output logic [bus_pkg::data_width-1:0] rdata
);
    import bus_pkg::*;

    // top bit of rd_sel is the I/O block, the rest are banks
    always_comb begin
        rdata = '0;  // no read in flight
        for (int b = 0; b < num_banks; b++) begin
            if (rd_sel[b]) begin
                rdata = bank_rdata[b];
            end
        end
        if (rd_sel[num_banks]) begin
            rdata = io_rdata;
        end
    end

    // two leaves driving one word would be a decoder fault
    always_comb begin
        if (!$isunknown(rd_sel)) begin
            sel_onehot: assert final ($onehot0(rd_sel))
                else $error("read mux sees several selects: %h", rd_sel);
        end
    end

endmodule

`default_nettype wire

// File: logic/io_handler.sv
`timescale 1ns/1ps
`default_nettype none

module io_handler (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             sel,
    input  bus_pkg::bus_req_t                req,
    input  logic [io_pkg::num_switches-1:0]  sw,
    output logic [bus_pkg::data_width-1:0]   rdata,
    output logic [io_pkg::num_leds-1:0]      ledr,
    output io_pkg::seg7_t                    hex0,
    output io_pkg::seg7_t                    hex1,
    output io_pkg::seg7_t                    hex2,
    output io_pkg::seg7_t                    hex3,
    output io_pkg::seg7_t                    hex4,
    output io_pkg::seg7_t                    hex5
);
    import bus_pkg::*;
    import io_pkg::*;

    logic [hex_width-1:0]        hex_value;
    logic [reg_offset_width-1:0] reg_off;
    logic                        reg_hit;
    logic [data_width-1:0]       lane_mask;
    logic [data_width-1:0]       rd_word;
    seg7_t                       digits [num_digits];

    function automatic seg7_t seg7_encode(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'ha: return 7'h08;
            4'hb: return 7'h03;
            4'hc: return 7'h46;
            4'hd: return 7'h21;
            4'he: return 7'h06;
            default: return 7'h0e;
        endcase
    endfunction

    assign reg_off = req.addr[reg_offset_width-1:0];
    assign reg_hit = req.addr[io_window_bits-1:reg_offset_width] == '0;  // upper offset clear

    always_comb begin
        for (int lane = 0; lane < be_width; lane++) begin
            lane_mask[lane*8 +: 8] = {8{req.be[lane]}};
        end
    end

    always_comb begin
        rd_word = '0;
        if (reg_hit) begin
            case (reg_off)
                ledr_offset: rd_word[num_leds-1:0]     = ledr;
                sw_offset:   rd_word[num_switches-1:0] = sw;  // sampled at the read edge
                hex_offset:  rd_word[hex_width-1:0]    = hex_value;
                default:     rd_word = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ledr      <= '0;
            hex_value <= '0;
            rdata     <= '0;
        end else if (sel && req.we) begin
            if (reg_hit && reg_off == ledr_offset) begin
                ledr <= (ledr & ~lane_mask[num_leds-1:0]) |
                        (req.wdata[num_leds-1:0] & lane_mask[num_leds-1:0]);
            end
            if (reg_hit && reg_off == hex_offset) begin
                hex_value <= (hex_value & ~lane_mask[hex_width-1:0]) |
                             (req.wdata[hex_width-1:0] & lane_mask[hex_width-1:0]);
            end
        end else if (sel) begin
            rdata <= rd_word;
        end
    end

    // hex0 is the least significant nibble
    always_comb begin
        for (int d = 0; d < num_digits; d++) begin
            digits[d] = seg7_encode(hex_value[d*4 +: 4]);
        end
    end

    assign hex0 = digits[0];
    assign hex1 = digits[1];
    assign hex2 = digits[2];
    assign hex3 = digits[3];
    assign hex4 = digits[4];
    assign hex5 = digits[5];

endmodule

`default_nettype wire

// File: logic/sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

module sram_bank (
    input  logic                           clk,
    input  logic                           sel,
    input  bus_pkg::bus_req_t              req,
    output logic [bus_pkg::data_width-1:0] rdata
);
    import bus_pkg::*;

    logic [data_width-1:0]       mem [bank_words];
    logic [bank_index_width-1:0] index;

    assign index = req.addr[bank_index_width+1:2];  // word address, bits 9..2

    // byte lane writes
    always_ff @(posedge clk) begin
        if (sel && req.we) begin
            for (int lane = 0; lane < be_width; lane++) begin
                if (req.be[lane]) begin
                    mem[index][lane*8 +: 8] <= req.wdata[lane*8 +: 8];
                end
            end
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        if (sel && !req.we) begin
            rdata <= mem[index];
        end
    end

    // a write with no lanes enabled means the master built a bad request
    write_has_lanes: assert property (@(posedge clk)
        (sel && req.we) |-> (req.be != '0))
        else $error("bank write at %h with no byte enables", req.addr);

endmodule

`default_nettype wire

// File: logic/address_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module address_decoder (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          as_n,
    input  bus_pkg::bus_req_t             req,
    output logic [bus_pkg::num_banks-1:0] bank_sel,
    output logic                          io_sel,
    output logic [bus_pkg::num_banks:0]   rd_sel
);
    import bus_pkg::*;

    logic                      ram_hit;
    logic                      io_hit;
    logic [bank_sel_width-1:0] bank_num;

    assign ram_hit  = (req.addr - ram_base) < ram_span;  // wraps below base
    assign io_hit   = req.addr[addr_width-1:io_window_bits] ==
                      io_base[addr_width-1:io_window_bits];
    assign bank_num = req.addr[bank_index_width+2 +: bank_sel_width];

    always_comb begin
        bank_sel = '0;
        if (!as_n && ram_hit) begin
            bank_sel[bank_num] = 1'b1;
        end
    end

    assign io_sel = !as_n && io_hit;

    // read select follows the read word by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_sel <= '0;
        end else if (req.we) begin
            rd_sel <= '0;  // writes leave rdata at zero
        end else begin
            rd_sel <= {io_sel, bank_sel};
        end
    end

    // at most one leaf answers a read
    rd_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(rd_sel))
        else $error("rd_sel has more than one bit set: %h", rd_sel);

endmodule

`default_nettype wire

// File: logic/io_pkg.sv
`default_nettype none

package io_pkg;

    // register file inside the I/O window
    localparam int reg_offset_width = 4;
    localparam logic [reg_offset_width-1:0] ledr_offset = 4'h0;  // read/write
    localparam logic [reg_offset_width-1:0] sw_offset   = 4'h4;  // read only
    localparam logic [reg_offset_width-1:0] hex_offset  = 4'h8;  // read/write

    // board peripherals
    localparam int num_leds     = 10;
    localparam int num_switches = 10;
    localparam int num_digits   = 6;
    localparam int hex_width    = num_digits * 4;  // one nibble per digit

    // active low, bit 0 is segment a, bit 6 is segment g
    typedef logic [6:0] seg7_t;

endpackage

`default_nettype wire

// File: logic/bus_pkg.sv
`default_nettype none

package bus_pkg;

    localparam int addr_width = 32;  // byte address
    localparam int data_width = 32;
    localparam int be_width   = data_width / 8;  // one enable per byte lane

    // RAM geometry
    localparam int num_banks        = 4;
    localparam int bank_words       = 256;
    localparam int bank_index_width = $clog2(bank_words);  // word index inside a bank
    localparam int bank_sel_width   = $clog2(num_banks);   // bank number above the index

    // address map
    localparam logic [addr_width-1:0] ram_base = 32'h0000_0000;
    localparam logic [addr_width-1:0] ram_span = num_banks * bank_words * be_width;
    localparam logic [addr_width-1:0] io_base  = 32'h0001_0000;
    localparam int io_window_bits              = 12;  // 4 KiB I/O window

    // one load/store request as the CPU data port presents it
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
        logic [be_width-1:0]   be;
        logic                  we;
    } bus_req_t;

endpackage

`default_nettype wire
